//--- hw/sprite_pkg.sv
// shared raster, object table and register map constants for the sprite overlay engine
`default_nettype none

package sprite_pkg;

    // raster timing in clocks and lines, two clocks per logical pixel
    localparam logic [10:0] H_TOTAL      = 11'd1600;
    localparam logic [10:0] H_ACTIVE     = 11'd1280;
    localparam logic [10:0] H_SYNC_START = 11'd1312;
    localparam logic [10:0] H_SYNC_END   = 11'd1503; // last sync clock, inclusive

    localparam logic [9:0]  V_TOTAL      = 10'd525;
    localparam logic [9:0]  V_ACTIVE     = 10'd480;
    localparam logic [9:0]  V_SYNC_LINE  = 10'd490; // vsync spans two lines from here

    // object table and sprite memory geometry
    localparam int NUM_OBJECTS  = 8;
    localparam int NUM_SPRITES  = 4;
    localparam int SPRITE_DIM   = 8;
    localparam int SPRITE_WORDS = NUM_SPRITES * SPRITE_DIM * SPRITE_DIM / 4; // 4 px per word

    // word addresses on the 7-bit bus, address 0 is the background
    localparam logic [6:0] OBJ_BASE = 7'd1;
    localparam logic [6:0] PIX_BASE = 7'd64;

    localparam logic [23:0] RESET_BG = 24'h008000;

    // clocks from counter position to the pins
    localparam int PIPE_DEPTH = 3;

    typedef enum logic [1:0] {
        REG_BG,
        REG_OBJ,
        REG_PIX,
        REG_NONE
    } reg_region_t;

endpackage

`default_nettype wire

//--- hw/vga_timing.sv
// horizontal and vertical raster counters with raw sync, blank and pixel clock decode
`default_nettype none

module vga_timing
    import sprite_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic [10:0] hcount,
    output logic [9:0]  vcount,
    output logic        hs_raw,
    output logic        vs_raw,
    output logic        blank_n_raw,
    output logic        pclk_raw
);

    logic end_of_line;
    logic end_of_field;

    assign end_of_line  = (hcount == H_TOTAL - 11'd1);
    assign end_of_field = (vcount == V_TOTAL - 10'd1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= 11'd0;
        end else if (end_of_line) begin
            hcount <= 11'd0;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // vertical steps once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= 10'd0;
        end else if (end_of_line) begin
            if (end_of_field) begin
                vcount <= 10'd0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end
    end

    // syncs are active low
    assign hs_raw = !((hcount >= H_SYNC_START) && (hcount <= H_SYNC_END));
    assign vs_raw = !((vcount >= V_SYNC_LINE) && (vcount < V_SYNC_LINE + 10'd2));

    assign blank_n_raw = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign pclk_raw    = hcount[0]; // half rate pixel clock

    // counters never leave their period, even across a frame wrap
    counters_in_range : assert property (
        @(posedge clk) disable iff (reset)
        (hcount < H_TOTAL) && (vcount < V_TOTAL)
    );

endmodule

`default_nettype wire

//--- hw/object_regs.sv
// bus write decode into the background register, object table and sprite memory port
`default_nettype none

module object_regs
    import sprite_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          chipselect,
    input  logic                          write,
    input  logic [6:0]                    address,
    input  logic [31:0]                   writedata,
    output logic [23:0]                   bg_color,
    output logic [NUM_OBJECTS-1:0][9:0]   obj_x,
    output logic [NUM_OBJECTS-1:0][9:0]   obj_y,
    output logic [NUM_OBJECTS-1:0][1:0]   obj_sprite,
    output logic [NUM_OBJECTS-1:0]        obj_active,
    output logic                          pix_we,
    output logic [5:0]                    pix_waddr,
    output logic [31:0]                   pix_wdata
);

    reg_region_t region;
    logic        wr_strobe;
    logic [6:0]  obj_off;
    logic [2:0]  obj_sel;

    assign wr_strobe = chipselect && write;
    assign obj_off   = address - OBJ_BASE;
    assign obj_sel   = obj_off[2:0];

    always_comb begin
        if (address == 7'd0) begin
            region = REG_BG;
        end else if (obj_off < 7'(NUM_OBJECTS)) begin
            region = REG_OBJ;
        end else if (address >= PIX_BASE) begin
            region = REG_PIX;
        end else begin
            region = REG_NONE; // gap between table and sprite words
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bg_color   <= RESET_BG;
            obj_active <= '0;
        end else if (wr_strobe) begin
            if (region == REG_BG) begin
                bg_color <= writedata[23:0];
            end else if (region == REG_OBJ) begin
                obj_active[obj_sel] <= writedata[1];
            end
        end
    end

    // position and sprite number, only meaningful once active
    always_ff @(posedge clk) begin
        if (wr_strobe && region == REG_OBJ) begin
            obj_x[obj_sel]      <= writedata[29:20]; // x bits 31:30 ignored
            obj_y[obj_sel]      <= writedata[17:8];
            obj_sprite[obj_sel] <= writedata[3:2];
        end
    end

    // memory itself lives in the renderer
    assign pix_we    = wr_strobe && (region == REG_PIX);
    assign pix_waddr = 6'(address - PIX_BASE);
    assign pix_wdata = writedata;

    // sprite words and unmapped writes leave background and table alone
    other_writes_keep_table : assert property (
        @(posedge clk) disable iff (reset)
        (wr_strobe && region != REG_BG && region != REG_OBJ)
            |=> ($stable(bg_color) && $stable(obj_active))
    );

endmodule

`default_nettype wire

//--- hw/color_palette.sv
// fixed 6x6x6 colour cube lookup from an 8-bit sprite index to 24-bit rgb
`default_nettype none

module color_palette (
    input  logic [7:0]  color_index,
    output logic [23:0] palette_rgb
);

    logic [7:0] r_lvl;
    logic [7:0] g_lvl;
    logic [7:0] b_lvl;

    // base-6 digits of the index
    assign r_lvl = color_index / 8'd36;
    assign g_lvl = (color_index / 8'd6) % 8'd6;
    assign b_lvl = color_index % 8'd6;

    always_comb begin
        if (color_index < 8'd216) begin
            palette_rgb = {r_lvl * 8'h33, g_lvl * 8'h33, b_lvl * 8'h33}; // steps of 0x33
        end else begin
            palette_rgb = 24'h000000; // top of the range is unused
        end
    end

endmodule

`default_nettype wire

//--- hw/sprite_render.sv
// three-stage sprite renderer: hit search, sprite memory read, colour select with delayed syncs
`default_nettype none

module sprite_render
    import sprite_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [23:0]                   bg_color,
    input  logic [NUM_OBJECTS-1:0][9:0]   obj_x,
    input  logic [NUM_OBJECTS-1:0][9:0]   obj_y,
    input  logic [NUM_OBJECTS-1:0][1:0]   obj_sprite,
    input  logic [NUM_OBJECTS-1:0]        obj_active,
    input  logic                          pix_we,
    input  logic [5:0]                    pix_waddr,
    input  logic [31:0]                   pix_wdata,
    input  logic [10:0]                   hcount,
    input  logic [9:0]                    vcount,
    input  logic                          hs_raw,
    input  logic                          vs_raw,
    input  logic                          blank_n_raw,
    input  logic                          pclk_raw,
    input  logic [23:0]                   palette_rgb,
    output logic [7:0]                    color_index,
    output logic [7:0]                    vga_r,
    output logic [7:0]                    vga_g,
    output logic [7:0]                    vga_b,
    output logic                          vga_clk,
    output logic                          vga_hs,
    output logic                          vga_vs,
    output logic                          vga_blank_n
);

    logic [31:0] sprite_mem [SPRITE_WORDS];

    logic [9:0]  px;
    logic [9:0]  dx;
    logic [9:0]  dy;
    logic        hit;
    logic [1:0]  hit_sprite;
    logic [2:0]  hit_row;
    logic [2:0]  hit_col;

    logic        s1_hit;
    logic [1:0]  s1_sprite;
    logic [2:0]  s1_row;
    logic [2:0]  s1_col;
    logic [31:0] s1_word;

    logic        s2_hit;
    logic [7:0]  s2_index;

    logic [23:0] rgb;
    logic [PIPE_DEPTH-1:0] hs_d;
    logic [PIPE_DEPTH-1:0] vs_d;
    logic [PIPE_DEPTH-1:0] blank_d;
    logic [PIPE_DEPTH-1:0] pclk_d;
    logic [PIPE_DEPTH-2:0] fill_d; // a real pixel has reached this stage

    assign px = hcount[10:1]; // logical pixel column

    // ascending scan, so the highest covering object is left standing
    always_comb begin
        hit        = 1'b0;
        hit_sprite = 2'd0;
        hit_row    = 3'd0;
        hit_col    = 3'd0;
        dx         = 10'd0;
        dy         = 10'd0;
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            dx = px - obj_x[i];
            dy = vcount - obj_y[i];
            if (obj_active[i] && px >= obj_x[i] && vcount >= obj_y[i] &&
                dx < SPRITE_DIM && dy < SPRITE_DIM) begin
                hit        = 1'b1;
                hit_sprite = obj_sprite[i];
                hit_row    = dy[2:0];
                hit_col    = dx[2:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_we) begin
            sprite_mem[pix_waddr] <= pix_wdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_hit <= 1'b0;
            s2_hit <= 1'b0;
        end else begin
            s1_hit <= hit;
            s2_hit <= s1_hit;
        end
    end

    // two words per sprite row, low byte is the leftmost pixel
    assign s1_word = sprite_mem[{s1_sprite, s1_row, s1_col[2]}];

    always_ff @(posedge clk) begin
        s1_sprite <= hit_sprite;
        s1_row    <= hit_row;
        s1_col    <= hit_col;
        s2_index  <= s1_word[s1_col[1:0]*8 +: 8];
    end

    assign color_index = s2_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgb <= 24'd0;
        end else if (!fill_d[PIPE_DEPTH-2]) begin
            rgb <= 24'd0; // pipeline still filling after reset
        end else if (!s2_hit || s2_index == 8'd0 || !blank_d[PIPE_DEPTH-2]) begin
            rgb <= bg_color; // index 0 is see-through
        end else begin
            rgb <= palette_rgb;
        end
    end

    // timing rides alongside the colour pipeline
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_d    <= '1;
            vs_d    <= '1;
            blank_d <= '0;
            pclk_d  <= '0;
            fill_d  <= '0;
        end else begin
            hs_d    <= {hs_d[PIPE_DEPTH-2:0], hs_raw};
            vs_d    <= {vs_d[PIPE_DEPTH-2:0], vs_raw};
            blank_d <= {blank_d[PIPE_DEPTH-2:0], blank_n_raw};
            pclk_d  <= {pclk_d[PIPE_DEPTH-2:0], pclk_raw};
            fill_d  <= {fill_d[PIPE_DEPTH-3:0], 1'b1};
        end
    end

    assign {vga_r, vga_g, vga_b} = rgb;
    assign vga_hs      = hs_d[PIPE_DEPTH-1];
    assign vga_vs      = vs_d[PIPE_DEPTH-1];
    assign vga_blank_n = blank_d[PIPE_DEPTH-1];
    assign vga_clk     = pclk_d[PIPE_DEPTH-1];

endmodule

`default_nettype wire

//--- hw/vga_sprite_top.sv
// top level of the sprite overlay engine, bus write port in and vga pins out
`default_nettype none

module vga_sprite_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [6:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_clk,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_blank_n,
    output logic        vga_sync_n
);

    logic [10:0]      hcount;
    logic [9:0]       vcount;
    logic             hs_raw;
    logic             vs_raw;
    logic             blank_n_raw;
    logic             pclk_raw;

    logic [23:0]      bg_color;
    logic [7:0][9:0]  obj_x;
    logic [7:0][9:0]  obj_y;
    logic [7:0][1:0]  obj_sprite;
    logic [7:0]       obj_active;
    logic             pix_we;
    logic [5:0]       pix_waddr;
    logic [31:0]      pix_wdata;

    logic [7:0]       color_index;
    logic [23:0]      palette_rgb;

    vga_timing u_timing (.*);

    object_regs u_regs (.*);

    sprite_render u_render (.*);

    // combinational, sits between stage 2 and stage 3 of the renderer
    color_palette u_palette (.*);

    assign vga_sync_n = 1'b0; // no sync on green

endmodule

`default_nettype wire

//--- verif/vga_checker.sv
// reference model of the register file and raster, compares every vga pin on each falling clock
`default_nettype none

module vga_checker
    import sprite_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        chipselect,
    input  wire logic        write,
    input  wire logic [6:0]  address,
    input  wire logic [31:0] writedata,
    input  wire logic [7:0]  vga_r,
    input  wire logic [7:0]  vga_g,
    input  wire logic [7:0]  vga_b,
    input  wire logic        vga_clk,
    input  wire logic        vga_hs,
    input  wire logic        vga_vs,
    input  wire logic        vga_blank_n,
    input  wire logic        vga_sync_n,
    output int               error_count,
    output int               check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [23:0] bg;
    logic [9:0]  ox [NUM_OBJECTS];
    logic [9:0]  oy [NUM_OBJECTS];
    logic [1:0]  os [NUM_OBJECTS];
    logic        oa [NUM_OBJECTS];
    logic [31:0] mem [SPRITE_WORDS];
    logic [27:0] pipe [$]; // {blank_n, hs, vs, clk, rgb} per position
    int          h;
    int          v;

    // 6x6x6 cube, 0x33 per step
    function automatic logic [23:0] cube_rgb(input int idx);
        int r;
        int g;
        int b;
        if (idx >= 216) begin
            return 24'h000000;
        end
        r = idx / 36;
        g = (idx / 6) % 6;
        b = idx % 6;
        return {8'(r * 51), 8'(g * 51), 8'(b * 51)};
    endfunction

    function automatic logic [23:0] pixel_rgb(input int hh, input int vv);
        int          px;
        int          win;
        int          dx;
        int          dy;
        logic [31:0] word;
        logic [7:0]  idx;
        px  = hh / 2;
        win = -1;
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            if (oa[i] && px >= int'(ox[i]) && px < int'(ox[i]) + 8 &&
                vv >= int'(oy[i]) && vv < int'(oy[i]) + 8) begin
                win = i; // later entries sit on top
            end
        end
        if (win < 0) begin
            return bg;
        end
        dx   = px - int'(ox[win]);
        dy   = vv - int'(oy[win]);
        word = mem[int'(os[win]) * 16 + dy * 2 + dx / 4];
        idx  = word[(dx % 4) * 8 +: 8];
        if (idx == 8'd0) begin
            return bg;
        end
        return cube_rgb(int'(idx));
    endfunction

    function automatic logic [27:0] expected_pins(input int hh, input int vv);
        logic blank_n;
        logic hs;
        logic vs;
        blank_n = (hh < 1280) && (vv < 480);
        hs      = !(hh >= 1312 && hh <= 1503);
        vs      = !(vv >= 490 && vv < 492);
        return {blank_n, hs, vs, 1'(hh % 2), blank_n ? pixel_rgb(hh, vv) : 24'd0};
    endfunction

    task automatic apply_write(input logic [6:0] addr, input logic [31:0] data);
        reg_region_t region;
        int          sel;
        if (addr == 7'd0) begin
            region = REG_BG;
        end else if (addr >= 7'd1 && addr <= 7'd8) begin
            region = REG_OBJ;
        end else if (addr >= 7'd64) begin
            region = REG_PIX;
        end else begin
            region = REG_NONE;
        end
        sel = int'(addr) - 1;
        case (region)
            REG_BG:  bg = data[23:0];
            REG_OBJ: begin
                ox[sel] = data[29:20]; // only low 10 bits of x take part
                oy[sel] = data[17:8];
                os[sel] = data[3:2];
                oa[sel] = data[1];
            end
            REG_PIX: mem[int'(addr) - 64] = data;
            default: ;
        endcase
    endtask

    task automatic report(input string what, input logic [27:0] exp, input logic [27:0] got);
        error_count++;
        $display("ERROR at %0t: %s expected %h got %h (line %0d)", $time, what, exp, got, v);
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        for (int w = 0; w < SPRITE_WORDS; w++) begin
            mem[w] = 32'd0;
        end
    end

    always @(negedge clk) begin
        logic [27:0] exp;
        logic [27:0] got;
        logic        startup;
        if (reset) begin
            pipe.delete();
            h  = 0;
            v  = 0;
            bg = RESET_BG;
            for (int i = 0; i < NUM_OBJECTS; i++) begin
                oa[i] = 1'b0;
                ox[i] = '0;
                oy[i] = '0;
                os[i] = '0;
            end
        end else begin
            startup = (pipe.size() < PIPE_DEPTH);
            exp = startup ? {1'b0, 1'b1, 1'b1, 1'b0, 24'd0} : pipe.pop_front();
            got = {vga_blank_n, vga_hs, vga_vs, vga_clk, vga_r, vga_g, vga_b};
            check_count++;
            if (exp[27:24] != got[27:24]) begin
                report("timing pins", exp, got);
            end else if ((startup || exp[27]) && exp[23:0] != got[23:0]) begin
                report("pixel colour", exp, got);
            end
            if (vga_sync_n !== 1'b0) begin
                report("vga_sync_n", 28'd0, {27'd0, vga_sync_n});
            end
            pipe.push_back(expected_pins(h, v));
            if (chipselect && write) begin
                apply_write(address, writedata); // lands on the coming rising edge
            end
            h = h + 1;
            if (h == 1600) begin
                h = 0;
                v = (v == 524) ? 0 : v + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
// testbench top, random register programming in vertical blanking against the raster checker
`default_nettype none

module tb_top
    import sprite_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int RUN_FRAMES   = 4; // reset up to first vsync, then three programmed frames

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [6:0]  address;
    logic [31:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_clk;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic        vga_sync_n;
    int          error_count;
    int          check_count;
    integer      seed;

    vga_sprite_top dut (.*);

    vga_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic bus_write(input logic [6:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    task automatic randomize_scene(input bit load_sprites);
        logic [31:0] word;
        logic [31:0] r;
        logic [9:0]  x;
        logic [9:0]  y;
        if (load_sprites) begin
            for (int w = 0; w < SPRITE_WORDS; w++) begin
                for (int b = 0; b < 4; b++) begin
                    r = $random(seed);
                    word[b * 8 +: 8] = (r[2:0] == 3'd0) ? 8'd0 : r[15:8]; // plenty of see-through
                end
                bus_write(PIX_BASE + 7'(w), word);
            end
        end
        bus_write(7'd0, $random(seed));
        // crowd the objects into a small window so they overlap often
        for (int i = 0; i < NUM_OBJECTS; i++) begin
            r = $random(seed);
            x = 10'd200 + 10'(r[5:0]);
            y = 10'd100 + 10'(r[10:6]);
            bus_write(OBJ_BASE + 7'(i), {r[31:30], x, r[29:28], y, r[27:24], r[13:12],
                                         (r[15:14] != 2'b00), r[16]});
        end
        for (int k = 0; k < 3; k++) begin
            r = $random(seed);
            bus_write(7'd9 + 7'(r[15:0] % 55), $random(seed)); // gap between table and sprites
        end
    endtask

    initial begin
        seed       = 92366;
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = 7'd0;
        writedata  = 32'd0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int f = 0; f < 3; f++) begin
            @(negedge vga_vs);
            randomize_scene(f == 0);
        end
        @(negedge vga_vs);
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // whole run ends at the last vsync, inside four frames
    initial begin
        #(8 * RUN_FRAMES * FRAME_CYCLES);
        $display("timeout: the run did not reach its last frame in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/sprite_pkg.sv
hw/vga_timing.sv
hw/object_regs.sv
hw/color_palette.sv
hw/sprite_render.sv
hw/vga_sprite_top.sv
verif/vga_checker.sv
verif/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sprite overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top -f sources.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
    exit 1
fi
exit 0
